// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_front_tb
FILELIST  ?= fetch_front.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(wildcard design/*.sv testbench/*.sv testbench/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/decode_latch.sv
`timescale 1ns/1ps
`default_nettype none

module decode_latch
    import fetch_pkg::*;
#(
    parameter int NUM_LINES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  line_t                 fetch_bytes,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] fetch_bip,
    input  logic                  fetch_ok,
    input  logic                  stall,
    output logic [LEN_W-1:0]      length,
    output logic                  advance,
    output packet_t               packet,
    output logic                  packet_valid
);

    //////////////////////////////////////////////////
    // length decode
    //////////////////////////////////////////////////

    // length is the low nibble of byte 0 plus one
    assign length = {1'b0, fetch_bytes[LINE_OFF_W-1:0]} + LEN_W'(1);

    assign advance = fetch_ok & ~stall;

    //////////////////////////////////////////////////
    // output packet
    //////////////////////////////////////////////////

    // held under stall
    always_ff @(posedge clk) begin
        if (advance) begin
            packet.bytes  <= fetch_bytes;
            packet.length <= length;
            packet.bip    <= PKT_BIP_W'(fetch_bip);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= advance;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_front.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front
    import fetch_pkg::*;
#(
    parameter int NUM_LINES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fill_valid,
    input  fill_t                 fill,
    input  logic                  stall,
    input  logic                  is_init,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] init_bip,
    input  logic                  is_resteer,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] wb_bip,
    input  logic                  is_br,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] bp_bip,
    output packet_t               packet,
    output logic                  packet_valid,
    output logic [NUM_LINES-1:0]  line_free
);

    localparam int BIP_W = $clog2(NUM_LINES * LINE_BYTES);

    line_t [NUM_LINES-1:0] lines;
    logic [NUM_LINES-1:0]  line_valid;
    logic [NUM_LINES-1:0]  line_release;
    logic                  flush;
    line_t                 fetch_bytes;
    logic [BIP_W-1:0]      fetch_bip;
    logic                  fetch_ok;
    logic [LEN_W-1:0]      length;
    logic                  advance;

    //////////////////////////////////////////////////
    // buffer, fetch and decode latch
    //////////////////////////////////////////////////

    ibuf_lines #(
        .NUM_LINES(NUM_LINES)
    ) ibuf_lines_i (
        .clk         (clk),
        .reset       (reset),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .line_release(line_release),
        .flush       (flush),
        .lines       (lines),
        .line_valid  (line_valid),
        .line_free   (line_free)
    );

    fetch_unit #(
        .NUM_LINES(NUM_LINES)
    ) fetch_unit_i (
        .clk         (clk),
        .reset       (reset),
        .lines       (lines),
        .line_valid  (line_valid),
        .length      (length),
        .advance     (advance),
        .is_init     (is_init),
        .init_bip    (init_bip),
        .is_resteer  (is_resteer),
        .wb_bip      (wb_bip),
        .is_br       (is_br),
        .bp_bip      (bp_bip),
        .fetch_bytes (fetch_bytes),
        .fetch_bip   (fetch_bip),
        .fetch_ok    (fetch_ok),
        .line_release(line_release),
        .flush       (flush)
    );

    decode_latch #(
        .NUM_LINES(NUM_LINES)
    ) decode_latch_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_bytes (fetch_bytes),
        .fetch_bip   (fetch_bip),
        .fetch_ok    (fetch_ok),
        .stall       (stall),
        .length      (length),
        .advance     (advance),
        .packet      (packet),
        .packet_valid(packet_valid)
    );

endmodule

`default_nettype wire

// File: design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    //////////////////////////////////////////////////
    // line and packet geometry
    //////////////////////////////////////////////////

    // bytes per buffer line, also the packet width in bytes
    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS  = LINE_BYTES * 8;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);

    // instruction length runs 1..16, so one bit more than the offset
    localparam int LEN_W = LINE_OFF_W + 1;

    // fill index and packet bip sized for the default four-line buffer
    localparam int FILL_IDX_W = 2;
    localparam int PKT_BIP_W  = 6;

    // byte k sits at bits 8k+7:8k
    typedef logic [LINE_BITS-1:0] line_t;

    typedef struct packed {
        logic [FILL_IDX_W-1:0] index;
        line_t                 data;
    } fill_t;

    //////////////////////////////////////////////////
    // redirect source, lowest to highest priority
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        REDIR_NONE    = 2'd0,
        REDIR_BRANCH  = 2'd1,
        REDIR_RESTEER = 2'd2,
        REDIR_INIT    = 2'd3
    } redirect_e;

    typedef struct packed {
        line_t                bytes;
        logic [LEN_W-1:0]     length;
        logic [PKT_BIP_W-1:0] bip;
    } packet_t;

endpackage

`default_nettype wire

// File: design/fetch_rotate.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_rotate
    import fetch_pkg::*;
#(
    parameter int NUM_LINES = 4
) (
    input  line_t [NUM_LINES-1:0] lines,
    input  logic [NUM_LINES-1:0]  line_valid,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] bip,
    output line_t                 fetch_bytes,
    output logic                  fetch_ok
);

    localparam int BIP_W      = $clog2(NUM_LINES * LINE_BYTES);
    localparam int LINE_IDX_W = $clog2(NUM_LINES);
    localparam int TOTAL_BITS = NUM_LINES * LINE_BITS;

    //////////////////////////////////////////////////
    // layered byte rotator
    //////////////////////////////////////////////////

    // stage s rotates right by 2^s bytes when bip[s] is set
    logic [TOTAL_BITS-1:0] rotated;

    always_comb begin
        rotated = lines;
        for (int s = 0; s < BIP_W; s++) begin
            if (bip[s]) begin
                rotated = (rotated >> (8 << s)) | (rotated << (TOTAL_BITS - (8 << s)));
            end
        end
    end

    // byte at bip now sits at byte 0
    assign fetch_bytes = rotated[LINE_BITS-1:0];

    //////////////////////////////////////////////////
    // two-line valid check
    //////////////////////////////////////////////////

    logic [LINE_IDX_W-1:0] cur_line;
    logic [LINE_IDX_W-1:0] next_line;

    assign cur_line  = bip[BIP_W-1:LINE_OFF_W];
    // wraps from the last line back to line 0
    assign next_line = cur_line + LINE_IDX_W'(1);

    assign fetch_ok = line_valid[cur_line] & line_valid[next_line];

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
#(
    parameter int NUM_LINES = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  line_t [NUM_LINES-1:0] lines,
    input  logic [NUM_LINES-1:0]  line_valid,
    input  logic [LEN_W-1:0]      length,
    input  logic                  advance,
    input  logic                  is_init,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] init_bip,
    input  logic                  is_resteer,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] wb_bip,
    input  logic                  is_br,
    input  logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] bp_bip,
    output line_t                 fetch_bytes,
    output logic [$clog2(NUM_LINES*LINE_BYTES)-1:0] fetch_bip,
    output logic                  fetch_ok,
    output logic [NUM_LINES-1:0]  line_release,
    output logic                  flush
);

    localparam int BIP_W = $clog2(NUM_LINES * LINE_BYTES);

    redirect_e         redir;
    logic [BIP_W-1:0]  redir_bip;
    logic [BIP_W-1:0]  bip;
    logic [BIP_W-1:0]  bip_sum;

    //////////////////////////////////////////////////
    // redirect priority
    //////////////////////////////////////////////////

    always_comb begin
        if (is_init) begin
            redir = REDIR_INIT;
        end else if (is_resteer) begin
            redir = REDIR_RESTEER;
        end else if (is_br) begin
            redir = REDIR_BRANCH;
        end else begin
            redir = REDIR_NONE;
        end
    end

    always_comb begin
        case (redir)
            REDIR_INIT:    redir_bip = init_bip;
            REDIR_RESTEER: redir_bip = wb_bip;
            REDIR_BRANCH:  redir_bip = bp_bip;
            default:       redir_bip = bip_sum;
        endcase
    end

    // branch keeps the buffer, the other two drop it
    assign flush = (redir == REDIR_INIT) || (redir == REDIR_RESTEER);

    //////////////////////////////////////////////////
    // bip register
    //////////////////////////////////////////////////

    // wraps modulo the buffer size
    assign bip_sum = bip + BIP_W'(length);

    always_ff @(posedge clk) begin
        if (reset) begin
            bip <= '0;
        end else if (redir != REDIR_NONE) begin
            bip <= redir_bip;
        end else if (advance) begin
            bip <= bip_sum;
        end
    end

    // leaving a line frees it on the same edge
    always_comb begin
        line_release = '0;
        if (advance && redir == REDIR_NONE &&
            bip_sum[BIP_W-1:LINE_OFF_W] != bip[BIP_W-1:LINE_OFF_W]) begin
            line_release[bip[BIP_W-1:LINE_OFF_W]] = 1'b1;
        end
    end

    assign fetch_bip = bip;

    fetch_rotate #(
        .NUM_LINES(NUM_LINES)
    ) fetch_rotate_i (
        .lines      (lines),
        .line_valid (line_valid),
        .bip        (bip),
        .fetch_bytes(fetch_bytes),
        .fetch_ok   (fetch_ok)
    );

    // decoder must never hand back a zero length on an accepted packet
    nonzero_length: assert property (
        @(posedge clk) disable iff (reset)
        advance |-> length != '0
    ) else $error("zero length on advance at bip %0h", bip);

endmodule

`default_nettype wire

// File: design/ibuf_lines.sv
`timescale 1ns/1ps
`default_nettype none

module ibuf_lines
    import fetch_pkg::*;
#(
    parameter int NUM_LINES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 fill_valid,
    input  fill_t                fill,
    input  logic [NUM_LINES-1:0] line_release,
    input  logic                 flush,
    output line_t [NUM_LINES-1:0] lines,
    output logic [NUM_LINES-1:0] line_valid,
    output logic [NUM_LINES-1:0] line_free
);

    line_t [NUM_LINES-1:0] line_mem;

    // line storage, written only by a fill
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            line_mem[fill.index] <= fill.data;
        end
    end

    assign lines = line_mem;

    //////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (flush) begin
                line_valid <= '0;
            end else begin
                line_valid <= line_valid & ~line_release;
            end
            // fill wins over a release of the same line
            if (fill_valid) begin
                line_valid[fill.index] <= 1'b1;
            end
        end
    end

    // free lines seen by the filler, one cycle behind the valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            line_free <= '1;
        end else begin
            line_free <= ~line_valid;
        end
    end

    // a fill must only land in a line that is empty or being let go
    fill_into_free_line: assert property (
        @(posedge clk) disable iff (reset)
        fill_valid && !flush |-> !line_valid[fill.index] || line_release[fill.index]
    ) else $error("fill into valid line %0d", fill.index);

endmodule

`default_nettype wire

// File: fetch_front.f
+incdir+testbench
design/fetch_pkg.sv
design/ibuf_lines.sv
design/fetch_rotate.sv
design/fetch_unit.sv
design/decode_latch.sv
design/fetch_front.sv
testbench/fetch_front_tb.sv

// File: testbench/fetch_front_table.svh
`ifndef FETCH_FRONT_TABLE_SVH
`define FETCH_FRONT_TABLE_SVH

    // stimulus operation of one table step
    typedef enum logic [2:0] {
        OP_IDLE,
        OP_FILL,
        OP_RUN,
        OP_STALL,
        OP_REDIRECT
    } op_e;

    // columns: op, redirect source, all three strobes, fill line, redirect target,
    // cycles, fewest and most packets expected over the step
    typedef struct packed {
        op_e        op;
        redirect_e  src;
        logic       all_strobes;
        logic [1:0] line;
        logic [5:0] target;
        int         cycles;
        int         min_pkts;
        int         max_pkts;
    } step_t;

    localparam int NUM_STEPS = 28;

    step_t step_table [NUM_STEPS];

    task automatic load_table();
        step_table[0]  = '{OP_IDLE,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  2, 0,  0};
        step_table[1]  = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  1, 0,  0};
        // next line missing, so nothing comes out
        step_table[2]  = '{OP_IDLE,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  3, 0,  0};
        step_table[3]  = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd1, 6'h00,  1, 0,  0};
        step_table[4]  = '{OP_STALL,    REDIR_NONE,    1'b0, 2'd0, 6'h00,  3, 0,  0};
        step_table[5]  = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        step_table[6]  = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd2, 6'h00,  1, 0,  0};
        step_table[7]  = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        step_table[8]  = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd3, 6'h00,  1, 0,  0};
        step_table[9]  = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        step_table[10] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  1, 0,  0};
        // wrap from line 3 into line 0
        step_table[11] = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        step_table[12] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd1, 6'h00,  1, 0,  0};
        step_table[13] = '{OP_STALL,    REDIR_NONE,    1'b0, 2'd0, 6'h00,  2, 0,  0};
        // branch lands while a packet is still accepted
        step_table[14] = '{OP_REDIRECT, REDIR_BRANCH,  1'b0, 2'd0, 6'h05,  1, 1,  1};
        step_table[15] = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        step_table[16] = '{OP_REDIRECT, REDIR_RESTEER, 1'b0, 2'd0, 6'h23,  1, 0,  0};
        step_table[17] = '{OP_IDLE,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  4, 0,  0};
        step_table[18] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd2, 6'h00,  1, 0,  0};
        step_table[19] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd3, 6'h00,  1, 0,  0};
        step_table[20] = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 1, 16};
        // init, resteer and branch all at once
        step_table[21] = '{OP_REDIRECT, REDIR_INIT,    1'b1, 2'd0, 6'h08,  1, 0,  0};
        step_table[22] = '{OP_IDLE,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  3, 0,  0};
        step_table[23] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd0, 6'h00,  1, 0,  0};
        step_table[24] = '{OP_FILL,     REDIR_NONE,    1'b0, 2'd1, 6'h00,  1, 0,  0};
        step_table[25] = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00,  1, 1,  1};
        step_table[26] = '{OP_STALL,    REDIR_NONE,    1'b0, 2'd0, 6'h00,  3, 0,  0};
        step_table[27] = '{OP_RUN,      REDIR_NONE,    1'b0, 2'd0, 6'h00, 20, 0, 16};
    endtask

`endif

// File: testbench/fetch_front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front_tb
    import fetch_pkg::*;
();

    localparam int NUM_LINES = 4;
    localparam int BIP_W     = $clog2(NUM_LINES * LINE_BYTES);
    localparam int MEM_BYTES = NUM_LINES * LINE_BYTES;
    localparam int MARGIN    = 50;

    logic                 clk;
    logic                 reset;
    logic                 fill_valid;
    fill_t                fill;
    logic                 stall;
    logic                 is_init;
    logic [BIP_W-1:0]     init_bip;
    logic                 is_resteer;
    logic [BIP_W-1:0]     wb_bip;
    logic                 is_br;
    logic [BIP_W-1:0]     bp_bip;
    packet_t              packet;
    logic                 packet_valid;
    logic [NUM_LINES-1:0] line_free;

    `include "fetch_front_table.svh"

    // reference model of the buffer, bip and output register
    logic [7:0]           model_mem [MEM_BYTES];
    logic [NUM_LINES-1:0] model_valid;
    logic [NUM_LINES-1:0] model_free;
    logic [BIP_W-1:0]     model_bip;
    packet_t              model_pkt;
    logic                 model_pvalid;
    logic                 have_pkt;

    logic [15:0] lfsr_state;
    int          error_count;
    int          step_pkts;
    int          cycle_count;
    int          cycle_limit;

    fetch_front #(
        .NUM_LINES(NUM_LINES)
    ) fetch_front_i (
        .clk         (clk),
        .reset       (reset),
        .fill_valid  (fill_valid),
        .fill        (fill),
        .stall       (stall),
        .is_init     (is_init),
        .init_bip    (init_bip),
        .is_resteer  (is_resteer),
        .wb_bip      (wb_bip),
        .is_br       (is_br),
        .bp_bip      (bp_bip),
        .packet      (packet),
        .packet_valid(packet_valid),
        .line_free   (line_free)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_packet(input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $write("mismatch packet: got bytes %h length %h bip %h,",
                   got.bytes, got.length, got.bip);
            $display(" expected bytes %h length %h bip %h",
                     exp.bytes, exp.length, exp.bip);
            error_count++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch packet_valid: got %h expected %h", got, exp);
            error_count++;
        end
    endtask

    task automatic check_free(input logic [NUM_LINES-1:0] got, input logic [NUM_LINES-1:0] exp);
        if (got !== exp) begin
            $display("mismatch line_free: got %h expected %h", got, exp);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // one clock of stimulus, model and checks
    //////////////////////////////////////////////////

    task automatic apply_cycle(input step_t s);
        line_t                data;
        packet_t              next_pkt;
        logic [BIP_W-1:0]     addr;
        logic [BIP_W-1:0]     next_bip;
        logic [BIP_W-1:0]     target;
        logic [NUM_LINES-1:0] next_valid;
        logic [1:0]           cur;
        logic                 adv;
        logic                 do_fill;
        data = '0;
        do_fill = (s.op == OP_FILL);
        if (do_fill) begin
            for (int j = 0; j < LINE_BITS; j++) begin
                lfsr_state = lfsr_next(lfsr_state);
                data[j] = lfsr_state[0];
            end
        end
        fill_valid = do_fill;
        fill.index = s.line;
        fill.data  = data;
        stall      = (s.op == OP_STALL);
        is_init    = (s.op == OP_REDIRECT) && (s.src == REDIR_INIT || s.all_strobes);
        is_resteer = (s.op == OP_REDIRECT) && (s.src == REDIR_RESTEER || s.all_strobes);
        is_br      = (s.op == OP_REDIRECT) && (s.src == REDIR_BRANCH || s.all_strobes);
        init_bip   = s.target;
        wb_bip     = s.target ^ (s.all_strobes ? BIP_W'('h15) : BIP_W'('h0));
        bp_bip     = s.target ^ (s.all_strobes ? BIP_W'('h2a) : BIP_W'('h0));

        // expected packet is the 16 bytes at bip with length from byte 0
        cur = model_bip[BIP_W-1:LINE_OFF_W];
        adv = model_valid[cur] && model_valid[cur + 2'd1] && !stall;
        for (int k = 0; k < LINE_BYTES; k++) begin
            addr = model_bip + BIP_W'(k);
            next_pkt.bytes[8*k +: 8] = model_mem[addr];
        end
        next_pkt.length = LEN_W'(model_mem[model_bip][3:0]) + LEN_W'(1);
        next_pkt.bip    = model_bip;

        if (is_init) begin
            target = init_bip;
        end else if (is_resteer) begin
            target = wb_bip;
        end else begin
            target = bp_bip;
        end
        next_valid = model_valid;
        next_bip   = model_bip;
        if (is_init || is_resteer || is_br) begin
            next_bip = target;
            if (is_init || is_resteer) begin
                next_valid = '0;
            end
        end else if (adv) begin
            next_bip = model_bip + BIP_W'(next_pkt.length);
            if (next_bip[BIP_W-1:LINE_OFF_W] != cur) begin
                next_valid[cur] = 1'b0;
            end
        end
        if (do_fill) begin
            next_valid[s.line] = 1'b1;
            for (int k = 0; k < LINE_BYTES; k++) begin
                model_mem[{s.line, LINE_OFF_W'(k)}] = data[8*k +: 8];
            end
        end

        model_free   = ~model_valid;
        model_pvalid = adv;
        if (adv) begin
            model_pkt = next_pkt;
            have_pkt  = 1'b1;
        end
        model_valid = next_valid;
        model_bip   = next_bip;

        @(posedge clk);
        @(negedge clk);
        check_valid(packet_valid, model_pvalid);
        check_free(line_free, model_free);
        if (have_pkt) begin
            check_packet(packet, model_pkt);
        end
        if (packet_valid === 1'b1) begin
            step_pkts++;
        end
    endtask

    //////////////////////////////////////////////////
    // run loop
    //////////////////////////////////////////////////

    initial begin
        step_t cur_step;
        op_e   cur_op;
        int    failed_steps;
        int    errors_before;
        clk          = 1'b0;
        reset        = 1'b1;
        fill_valid   = 1'b0;
        fill         = '0;
        stall        = 1'b0;
        is_init      = 1'b0;
        init_bip     = '0;
        is_resteer   = 1'b0;
        wb_bip       = '0;
        is_br        = 1'b0;
        bp_bip       = '0;
        lfsr_state   = 16'd29650;
        error_count  = 0;
        failed_steps = 0;
        model_valid  = '0;
        model_free   = '1;
        model_bip    = '0;
        model_pkt    = '0;
        model_pvalid = 1'b0;
        have_pkt     = 1'b0;
        load_table();
        cycle_limit = 5 + MARGIN;
        for (int i = 0; i < NUM_STEPS; i++) begin
            cycle_limit += step_table[i].cycles;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_valid(packet_valid, 1'b0);
        check_free(line_free, '1);

        for (int i = 0; i < NUM_STEPS; i++) begin
            cur_step      = step_table[i];
            cur_op        = cur_step.op;
            step_pkts     = 0;
            errors_before = error_count;
            for (int c = 0; c < cur_step.cycles; c++) begin
                apply_cycle(cur_step);
            end
            if (step_pkts < cur_step.min_pkts || step_pkts > cur_step.max_pkts) begin
                $display("step %0d produced %0d packets where %0d to %0d were expected",
                         i, step_pkts, cur_step.min_pkts, cur_step.max_pkts);
                error_count++;
            end
            if (error_count != errors_before) begin
                failed_steps++;
            end
            $display("step %0d %s: %0d cycles, %0d packets, %s", i, cur_op.name(),
                     cur_step.cycles, step_pkts, (error_count == errors_before) ? "ok" : "FAILED");
        end

        $display("%0d steps run, %0d failed, %0d errors", NUM_STEPS, failed_steps, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
